// ==== common/scpad_pkg.sv ====
package scpad_pkg;

    // scratchpad row and dram beat geometry
    localparam int ROW_WIDTH  = 512;
    localparam int BEAT_WIDTH = 64;

    // lanes per row, one beat per lane
    localparam int MAX_BEATS = ROW_WIDTH / BEAT_WIDTH;

    // dram byte address
    localparam int DRAM_ADDR_WIDTH = 32;

    // count from 0 up to and including MAX_BEATS
    localparam int BEAT_CNT_WIDTH = 4;

    // byte count carried along with each write beat
    localparam int NUM_BYTES_WIDTH = 7;

    // sized for the largest bank, 256 rows
    localparam int ROW_IDX_WIDTH = 8;

    typedef logic [ROW_IDX_WIDTH-1:0] row_idx_t;

    // write-back command from the host
    typedef struct packed {
        // source row in the scratchpad
        row_idx_t                   row_idx;
        // base byte address, low six bits are ignored
        logic [DRAM_ADDR_WIDTH-1:0] dram_addr;
        // 1 to MAX_BEATS
        logic [BEAT_CNT_WIDTH-1:0]  num_beats;
        // copied into every beat of this command
        logic [NUM_BYTES_WIDTH-1:0] num_bytes;
    } wb_cmd_t;

    // one 64-bit beat toward the dram backend
    typedef struct packed {
        logic                       valid;
        logic [BEAT_WIDTH-1:0]      wdata;
        logic [DRAM_ADDR_WIDTH-1:0] dram_addr;
        logic [NUM_BYTES_WIDTH-1:0] num_bytes;
    } dram_write_req_t;

endpackage

// ==== src/scpad_bank.sv ====
`timescale 1ns/1ps

module scpad_bank #(
    parameter int NUM_ROWS = 64
) (
    input  logic                           clk,
    input  logic                           n_rst,

    // host write port
    input  logic                           wr_en,
    input  scpad_pkg::row_idx_t            wr_idx,
    input  logic [scpad_pkg::ROW_WIDTH-1:0] wr_data,

    // read port, data one cycle after rd_en
    input  logic                           rd_en,
    input  scpad_pkg::row_idx_t            rd_idx,
    output logic [scpad_pkg::ROW_WIDTH-1:0] rd_data
);

    // only as many index bits as the bank has rows
    localparam int IDX_WIDTH = $clog2(NUM_ROWS);

    logic [scpad_pkg::ROW_WIDTH-1:0] rows [NUM_ROWS];

    logic [IDX_WIDTH-1:0] wr_row;
    logic [IDX_WIDTH-1:0] rd_row;

    assign wr_row = wr_idx[IDX_WIDTH-1:0];
    assign rd_row = rd_idx[IDX_WIDTH-1:0];

    // row storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            rows[wr_row] <= wr_data;
        end
    end

    // registered read, holds between reads
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= rows[rd_row];
        end
    end

endmodule

// ==== dram_write/writeback_ctrl.sv ====
`timescale 1ns/1ps

module writeback_ctrl (
    input  logic                            clk,
    input  logic                            n_rst,

    // command from the host
    input  logic                            cmd_valid,
    input  scpad_pkg::wb_cmd_t              cmd,

    // bank read
    output logic                            rd_en,
    output scpad_pkg::row_idx_t             rd_idx,
    input  logic [scpad_pkg::ROW_WIDTH-1:0] rd_data,

    // held values for the beat splitter
    output logic [scpad_pkg::ROW_WIDTH-1:0] row_data,
    output scpad_pkg::wb_cmd_t              held_cmd,
    output logic                            start,
    input  logic                            latched,

    output logic                            busy
);

    typedef enum logic [1:0] {
        IDLE,
        READ,
        ISSUE
    } state_t;

    state_t state, nxt_state;

    logic accept;
    logic load_row;

    // only one command in flight, anything else while busy is dropped
    assign accept = cmd_valid && (state == IDLE);

    // rd_data is valid on the first issue cycle, start not yet raised
    assign load_row = (state == ISSUE) && !start;

    always_comb begin
        nxt_state = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    nxt_state = READ;
                end
            end
            READ: begin
                nxt_state = ISSUE;
            end
            ISSUE: begin
                if (latched) begin
                    nxt_state = IDLE;
                end
            end
            default: begin
                nxt_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state <= IDLE;
            start <= 1'b0;
        end else begin
            state <= nxt_state;
            // start stays up until the splitter reports the last beat
            if (latched) begin
                start <= 1'b0;
            end else if (load_row) begin
                start <= 1'b1;
            end
        end
    end

    // command and row payload
    always_ff @(posedge clk) begin
        if (accept) begin
            held_cmd <= cmd;
        end
        if (load_row) begin
            row_data <= rd_data;
        end
    end

    // single bank read in the read state
    assign rd_en  = (state == READ);
    assign rd_idx = held_cmd.row_idx;

    assign busy = (state != IDLE);

endmodule

// ==== dram_write/dram_write_latch.sv ====
`timescale 1ns/1ps

module dram_write_latch (
    input  logic                            clk,
    input  logic                            n_rst,

    // held row and command from the controller
    input  logic                            start,
    input  logic [scpad_pkg::ROW_WIDTH-1:0] row_data,
    input  scpad_pkg::wb_cmd_t              cmd,

    // backend stall level
    input  logic                            dram_be_busy,

    output scpad_pkg::dram_write_req_t      dram_write_req,
    output logic                            latch_busy,
    output logic                            latched
);

    scpad_pkg::dram_write_req_t nxt_req;

    // beats captured so far for this command
    logic [scpad_pkg::BEAT_CNT_WIDTH-1:0] count, nxt_count;

    logic [2:0]                            lane_idx;
    logic [scpad_pkg::BEAT_WIDTH-1:0]      lane_data;
    logic [scpad_pkg::DRAM_ADDR_WIDTH-1:0] beat_addr;

    logic beats_left;
    logic all_sent;

    always_comb begin
        lane_idx  = count[2:0];
        // lane 0 is the lowest 64 bits, lane 7 is bits 511 to 448
        lane_data = row_data[lane_idx*scpad_pkg::BEAT_WIDTH +: scpad_pkg::BEAT_WIDTH];
        // 64-byte aligned base, beat index in bits 5 to 3
        beat_addr = {cmd.dram_addr[scpad_pkg::DRAM_ADDR_WIDTH-1:6], lane_idx, 3'b000};
    end

    assign beats_left = start && (count < cmd.num_beats);
    assign all_sent   = start && (count == cmd.num_beats);

    assign latch_busy = beats_left;

    // last beat is on the bus and the backend takes it this cycle
    assign latched = all_sent && !dram_be_busy;

    always_comb begin
        nxt_req   = dram_write_req;
        nxt_count = count;

        // a stalled backend freezes both the request and the count
        if (!dram_be_busy) begin
            if (beats_left) begin
                nxt_req.valid     = 1'b1;
                nxt_req.wdata     = lane_data;
                nxt_req.dram_addr = beat_addr;
                nxt_req.num_bytes = cmd.num_bytes;
                nxt_count         = count + 1'b1;
            end else if (all_sent) begin
                nxt_req   = '0;
                nxt_count = '0;
            end
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            dram_write_req <= '0;
            count          <= '0;
        end else begin
            dram_write_req <= nxt_req;
            count          <= nxt_count;
        end
    end

endmodule

// ==== src/scpad_writeback.sv ====
`timescale 1ns/1ps

module scpad_writeback #(
    parameter int NUM_ROWS = 64
) (
    input  logic                            clk,
    input  logic                            n_rst,

    // host row writes
    input  logic                            row_wr_en,
    input  scpad_pkg::row_idx_t             row_wr_idx,
    input  logic [scpad_pkg::ROW_WIDTH-1:0] row_wr_data,

    // write-back command
    input  logic                            wb_cmd_valid,
    input  scpad_pkg::wb_cmd_t              wb_cmd,

    // dram backend
    input  logic                            dram_be_busy,
    output scpad_pkg::dram_write_req_t      dram_write_req,

    output logic                            wb_busy,
    output logic                            wb_done
);

    logic                            rd_en;
    scpad_pkg::row_idx_t             rd_idx;
    logic [scpad_pkg::ROW_WIDTH-1:0] rd_data;

    logic [scpad_pkg::ROW_WIDTH-1:0] row_data;
    scpad_pkg::wb_cmd_t              held_cmd;
    logic                            start;

    scpad_bank #(
        .NUM_ROWS (NUM_ROWS)
    ) u_bank (
        .clk     (clk),
        .n_rst   (n_rst),
        .wr_en   (row_wr_en),
        .wr_idx  (row_wr_idx),
        .wr_data (row_wr_data),
        .rd_en   (rd_en),
        .rd_idx  (rd_idx),
        .rd_data (rd_data)
    );

    writeback_ctrl u_ctrl (
        .clk       (clk),
        .n_rst     (n_rst),
        .cmd_valid (wb_cmd_valid),
        .cmd       (wb_cmd),
        .rd_en     (rd_en),
        .rd_idx    (rd_idx),
        .rd_data   (rd_data),
        .row_data  (row_data),
        .held_cmd  (held_cmd),
        .start     (start),
        .latched   (wb_done),
        .busy      (wb_busy)
    );

    // latch_busy stays internal
    dram_write_latch u_latch (
        .clk            (clk),
        .n_rst          (n_rst),
        .start          (start),
        .row_data       (row_data),
        .cmd            (held_cmd),
        .dram_be_busy   (dram_be_busy),
        .dram_write_req (dram_write_req),
        .latch_busy     (),
        .latched        (wb_done)
    );

endmodule

// ==== dv/scpad_writeback_checker.sv ====
`timescale 1ns/1ps

module scpad_writeback_checker (
    input logic                                 clk,
    input logic                                 n_rst,
    input logic                                 dram_be_busy,
    input scpad_pkg::dram_write_req_t           dram_write_req,
    input logic                                 latch_busy,
    input logic                                 latched,
    input logic [scpad_pkg::BEAT_CNT_WIDTH-1:0] count
);

    // request register comes out of reset empty
    valid_low_after_reset: assert property (
        @(posedge clk) $rose(n_rst) |-> !dram_write_req.valid
    ) else $error("dram_write_req.valid high in the first cycle after reset");

    // a stalled backend sees the same request on the next cycle
    hold_under_stall: assert property (
        @(posedge clk) disable iff (!n_rst) dram_be_busy |=> $stable(dram_write_req)
    ) else $error("dram_write_req changed while dram_be_busy was high");

    // the end pulse only comes once no beats remain
    latched_not_busy: assert property (
        @(posedge clk) disable iff (!n_rst) !(latched && latch_busy)
    ) else $error("latched and latch_busy high in the same cycle");

    count_in_range: assert property (
        @(posedge clk) disable iff (!n_rst)
            count <= scpad_pkg::BEAT_CNT_WIDTH'(scpad_pkg::MAX_BEATS)
    ) else $error("beat count above the number of lanes");

endmodule

bind dram_write_latch scpad_writeback_checker i_checker (
    .clk            (clk),
    .n_rst          (n_rst),
    .dram_be_busy   (dram_be_busy),
    .dram_write_req (dram_write_req),
    .latch_busy     (latch_busy),
    .latched        (latched),
    .count          (count)
);

// ==== dv/scpad_writeback_tb.sv ====
`timescale 1ns/1ps

module scpad_writeback_tb;

    localparam int NUM_ROWS    = 64;
    localparam int CLK_HALF    = 20;
    localparam int DRIVE_DELAY = 2;
    localparam int FIXED_CMDS  = 8;
    localparam int RANDOM_CMDS = 40;
    localparam int NUM_CMDS    = FIXED_CMDS + RANDOM_CMDS + 1;
    // cycles allowed per command including row writes and resets
    localparam int CMD_CYCLES  = 200;
    localparam int TIMEOUT_NS  = NUM_CMDS * CMD_CYCLES * 2 * CLK_HALF;
    localparam logic [31:0] SEED = 32'h2f4a_b383;

    logic                            clk;
    logic                            n_rst;
    logic                            row_wr_en;
    scpad_pkg::row_idx_t             row_wr_idx;
    logic [scpad_pkg::ROW_WIDTH-1:0] row_wr_data;
    logic                            wb_cmd_valid;
    scpad_pkg::wb_cmd_t              wb_cmd;
    logic                            dram_be_busy;
    scpad_pkg::dram_write_req_t      dram_write_req;
    logic                            wb_busy;
    logic                            wb_done;

    // model of row contents, pending beats and the expected busy level
    logic [scpad_pkg::ROW_WIDTH-1:0] exp_rows [256];
    scpad_pkg::dram_write_req_t      exp_beats [$];
    logic                            exp_busy;
    logic                            stall_en;
    int                              beat_errors;
    int                              ctrl_errors;
    int                              accepted;
    int                              done_seen;

    scpad_writeback #(
        .NUM_ROWS (NUM_ROWS)
    ) i_dut (
        .clk            (clk),
        .n_rst          (n_rst),
        .row_wr_en      (row_wr_en),
        .row_wr_idx     (row_wr_idx),
        .row_wr_data    (row_wr_data),
        .wb_cmd_valid   (wb_cmd_valid),
        .wb_cmd         (wb_cmd),
        .dram_be_busy   (dram_be_busy),
        .dram_write_req (dram_write_req),
        .wb_busy        (wb_busy),
        .wb_done        (wb_done)
    );

    initial clk = 1'b0;
    always #(CLK_HALF) clk = ~clk;

    // backend stalls about one cycle in four when enabled
    always @(posedge clk) begin
        #(DRIVE_DELAY);
        if (stall_en) begin
            dram_be_busy = ($urandom() % 4) == 0;
        end else begin
            dram_be_busy = 1'b0;
        end
    end

    task automatic step();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    // lane i is bits 64*i upward and the address steps 8 bytes from the aligned base
    task automatic push_beats(input scpad_pkg::wb_cmd_t c);
        scpad_pkg::dram_write_req_t      beat;
        logic [scpad_pkg::DRAM_ADDR_WIDTH-1:0] base;
        base = c.dram_addr & ~32'h3f;
        for (int i = 0; i < int'(c.num_beats); i++) begin
            beat.valid     = 1'b1;
            beat.wdata     = exp_rows[c.row_idx][i*scpad_pkg::BEAT_WIDTH +: scpad_pkg::BEAT_WIDTH];
            beat.dram_addr = base + 32'(i * 8);
            beat.num_bytes = c.num_bytes;
            exp_beats.push_back(beat);
        end
    endtask

    // sampled mid-cycle where inputs and outputs have settled
    always @(negedge clk) begin : monitor
        scpad_pkg::dram_write_req_t exp_req;
        logic                       last_beat;
        last_beat = 1'b0;
        if (!n_rst) begin
            exp_busy = 1'b0;
            exp_beats.delete();
        end else begin
            if (wb_busy != exp_busy) begin
                $display("FAILED wb_busy exp=%h got=%h at %0t", exp_busy, wb_busy, $time);
                ctrl_errors++;
            end
            if (dram_write_req.valid && !dram_be_busy) begin
                if (exp_beats.size() == 0) begin
                    $display("a beat was delivered with no beat expected at %0t", $time);
                    beat_errors++;
                end else begin
                    exp_req = exp_beats.pop_front();
                    if (dram_write_req.wdata != exp_req.wdata) begin
                        $display("FAILED dram_write_req.wdata exp=%h got=%h",
                                 exp_req.wdata, dram_write_req.wdata);
                        beat_errors++;
                    end
                    if (dram_write_req.dram_addr != exp_req.dram_addr) begin
                        $display("FAILED dram_write_req.dram_addr exp=%h got=%h",
                                 exp_req.dram_addr, dram_write_req.dram_addr);
                        beat_errors++;
                    end
                    if (dram_write_req.num_bytes != exp_req.num_bytes) begin
                        $display("FAILED dram_write_req.num_bytes exp=%h got=%h",
                                 exp_req.num_bytes, dram_write_req.num_bytes);
                        beat_errors++;
                    end
                    last_beat = (exp_beats.size() == 0);
                end
            end
            // done comes with the delivery of the final beat
            if (wb_done != last_beat) begin
                $display("FAILED wb_done exp=%h got=%h at %0t", last_beat, wb_done, $time);
                ctrl_errors++;
            end
            if (wb_done) begin
                done_seen++;
            end
            if (last_beat) begin
                exp_busy = 1'b0;
            end else if (wb_cmd_valid && !exp_busy) begin
                push_beats(wb_cmd);
                accepted++;
                exp_busy = 1'b1;
            end
        end
    end

    task automatic write_row(input scpad_pkg::row_idx_t idx);
        logic [scpad_pkg::ROW_WIDTH-1:0] data;
        for (int w = 0; w < scpad_pkg::ROW_WIDTH / 32; w++) begin
            data[w*32 +: 32] = $urandom();
        end
        row_wr_en   = 1'b1;
        row_wr_idx  = idx;
        row_wr_data = data;
        exp_rows[idx] = data;
        step();
        row_wr_en = 1'b0;
    endtask

    function automatic scpad_pkg::wb_cmd_t random_cmd(input int beats);
        scpad_pkg::wb_cmd_t c;
        logic [31:0]        r;
        r = $urandom();
        c.row_idx   = 8'(r % NUM_ROWS);
        c.dram_addr = $urandom();
        c.num_beats = 4'(beats);
        c.num_bytes = 7'($urandom());
        return c;
    endfunction

    // one accepted command optionally followed by commands that must be dropped
    task automatic run_cmd(input int beats, input logic try_drop);
        int drop_cycles;
        int done_before;
        while (exp_busy) begin
            step();
        end
        done_before  = done_seen;
        wb_cmd_valid = 1'b1;
        wb_cmd       = random_cmd(beats);
        step();
        if (try_drop) begin
            drop_cycles = $urandom_range(3, 1);
            repeat (drop_cycles) begin
                wb_cmd = random_cmd($urandom_range(scpad_pkg::MAX_BEATS, 1));
                step();
            end
        end
        wb_cmd_valid = 1'b0;
        while (exp_busy) begin
            step();
        end
        if (done_seen != done_before + 1) begin
            $display("a command sent while idle did not end with exactly one wb_done pulse");
            ctrl_errors++;
        end
    endtask

    task automatic apply_reset();
        n_rst = 1'b0;
        repeat (4) step();
        n_rst = 1'b1;
    endtask

    task automatic check_idle();
        #1;
        if (wb_busy || wb_done || dram_write_req.valid) begin
            $display("FAILED reset state wb_busy=%h wb_done=%h dram_write_req.valid=%h",
                     wb_busy, wb_done, dram_write_req.valid);
            ctrl_errors++;
        end
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("timeout, the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Test failed");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        n_rst        = 1'b0;
        row_wr_en    = 1'b0;
        row_wr_idx   = '0;
        row_wr_data  = '0;
        wb_cmd_valid = 1'b0;
        wb_cmd       = '0;
        dram_be_busy = 1'b0;
        stall_en     = 1'b0;
        exp_busy     = 1'b0;
        beat_errors  = 0;
        ctrl_errors  = 0;
        accepted     = 0;
        done_seen    = 0;

        apply_reset();
        check_idle();
        for (int r = 0; r < NUM_ROWS; r++) begin
            write_row(8'(r));
        end

        // full rows without stall
        for (int n = 0; n < FIXED_CMDS; n++) begin
            run_cmd(scpad_pkg::MAX_BEATS, 1'b0);
        end

        // random lengths with backend stall and dropped commands
        stall_en = 1'b1;
        for (int n = 0; n < RANDOM_CMDS; n++) begin
            if ($urandom_range(3, 0) == 0) begin
                write_row(8'($urandom_range(NUM_ROWS - 1, 0)));
            end
            run_cmd($urandom_range(scpad_pkg::MAX_BEATS, 1), 1'(n % 2));
        end

        // rows survive a reset in the middle of the run
        stall_en = 1'b0;
        apply_reset();
        check_idle();
        run_cmd(scpad_pkg::MAX_BEATS, 1'b0);
        repeat (4) step();

        if (exp_beats.size() != 0 || done_seen != accepted || accepted != NUM_CMDS) begin
            $display("command count mismatch, sent %0d, accepted %0d, done %0d",
                     NUM_CMDS, accepted, done_seen);
            ctrl_errors++;
        end
        $display("errors: beat=%0d control=%0d commands=%0d",
                 beat_errors, ctrl_errors, accepted);
        if (beat_errors == 0 && ctrl_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
common/scpad_pkg.sv
src/scpad_bank.sv
dram_write/writeback_ctrl.sv
dram_write/dram_write_latch.sv
src/scpad_writeback.sv
dv/scpad_writeback_checker.sv
dv/scpad_writeback_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

{
    verilator --binary --timing --assert -f vlog.f \
        --top-module scpad_writeback_tb -o scpad_writeback_sim &&
    ./obj_dir/scpad_writeback_sim | tee /dev/stderr |
        grep -q "Test completed successfully" &&
    echo "simulation passed"
} || {
    echo "simulation failed"
    exit 1
}
